/* compile.f */
wb_bridge_pkg.sv
wb64_to_wb32_bridge.sv
wb32_arbiter.sv
wb32_sram.sv
dual_port_mem_top.sv
tb_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_top -f compile.f -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import wb_bridge_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int TIMEOUT_CYCLES = 20000; // tests need well under a tenth of this
    localparam int REF_BYTES      = 4 * (2 ** MEM_WORDS_LOG2);

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   cyc_w [2]; // index 0 is fetch, 1 is data
    logic                   stb_w [2];
    logic                   we_w  [2];
    logic [WIDE_ADDR_W-1:0] adr_w [2];
    logic [WIDE_DATA_W-1:0] dat_w [2];
    logic [WIDE_SEL_W-1:0]  sel_w [2];
    cti_e                   cti_w [2];
    bte_e                   bte_w [2];
    logic [WIDE_DATA_W-1:0] dat_r [2];
    logic                   ack_r [2];

    logic [15:0]            lfsr_q;
    logic [7:0]             ref_mem [REF_BYTES]; // byte image of the sram
    logic [WIDE_DATA_W-1:0] exp_q [$];
    logic [WIDE_DATA_W-1:0] alt_q [$];         // second legal value, same as exp if none
    logic [WIDE_DATA_W-1:0] act_q [$];
    int                     ack_cnt [2];
    int                     error_cnt, check_cnt;
    int                     other_errs, tests_run, tests_failed;
    int                     err_base;          // compare errors counted before this test

    dual_port_mem_top dual_port_mem_top_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_cyc_i (cyc_w[0]),
        .fetch_stb_i (stb_w[0]),
        .fetch_we_i  (we_w[0]),
        .fetch_adr_i (adr_w[0]),
        .fetch_dat_i (dat_w[0]),
        .fetch_sel_i (sel_w[0]),
        .fetch_cti_i (cti_w[0]),
        .fetch_bte_i (bte_w[0]),
        .fetch_dat_o (dat_r[0]),
        .fetch_ack_o (ack_r[0]),
        .data_cyc_i  (cyc_w[1]),
        .data_stb_i  (stb_w[1]),
        .data_we_i   (we_w[1]),
        .data_adr_i  (adr_w[1]),
        .data_dat_i  (dat_w[1]),
        .data_sel_i  (sel_w[1]),
        .data_cti_i  (cti_w[1]),
        .data_bte_i  (bte_w[1]),
        .data_dat_o  (dat_r[1]),
        .data_ack_o  (ack_r[1])
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fibonacci lfsr, taps 16 14 13 11, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // address of the next beat, wrap-N stays in its aligned group of N
    function automatic logic [WIDE_ADDR_W-1:0] burst_next(
        input logic [WIDE_ADDR_W-1:0] a,
        input bte_e                   bte
    );
        int n;
        int base;
        case (bte)
            BTE_WRAP4:  n = 4;
            BTE_WRAP8:  n = 8;
            BTE_WRAP16: n = 16;
            default:    n = 0;
        endcase
        if (n == 0) begin
            return a + 1'b1;
        end
        base = int'(a) - int'(a) % n;
        return WIDE_ADDR_W'(base + (int'(a) % n + 1) % n);
    endfunction

    task automatic ref_write(input logic [WIDE_ADDR_W-1:0] a, input logic [WIDE_DATA_W-1:0] d,
                             input logic [WIDE_SEL_W-1:0] sel);
        for (int b = 0; b < WIDE_SEL_W; b++) begin
            if (sel[b]) begin
                ref_mem[{a[MEM_WORDS_LOG2-2:0], 3'(b)}] = d[8*b +: 8]; // aliases like the sram
            end
        end
    endtask

    function automatic logic [WIDE_DATA_W-1:0] ref_read(input logic [WIDE_ADDR_W-1:0] a);
        logic [WIDE_DATA_W-1:0] r;
        for (int b = 0; b < WIDE_SEL_W; b++) begin
            r[8*b +: 8] = ref_mem[{a[MEM_WORDS_LOG2-2:0], 3'(b)}];
        end
        return r;
    endfunction

    task automatic queue_check(input logic [WIDE_DATA_W-1:0] exp_v, alt_v, act_v);
        exp_q.push_back(exp_v);
        alt_q.push_back(alt_v);
        act_q.push_back(act_v);
    endtask

    // one wide master on port p, a single beat or an incrementing burst
    task automatic wide_burst(input logic p, input logic we, input logic [WIDE_ADDR_W-1:0] start,
                              input int beats, input bte_e bte, input logic [WIDE_SEL_W-1:0] sel,
                              input logic check, output logic [WIDE_DATA_W-1:0] rd);
        logic [WIDE_ADDR_W-1:0] a;
        a  = start;
        rd = '0;
        for (int i = 0; i < beats; i++) begin
            cyc_w[p] = 1'b1;
            stb_w[p] = 1'b1;
            we_w[p]  = we;
            adr_w[p] = a;
            dat_w[p] = we ? {rand_bits(32), rand_bits(32)} : '0;
            sel_w[p] = sel;
            bte_w[p] = bte;
            if (beats == 1) begin
                cti_w[p] = CTI_CLASSIC;
            end else begin
                cti_w[p] = (i == beats - 1) ? CTI_END : CTI_INCR;
            end
            @(negedge clk);
            while (!ack_r[p]) begin
                @(negedge clk);
            end
            if (we) begin
                ref_write(a, dat_w[p], sel);
            end else begin
                rd = dat_r[p];
                if (check) begin
                    queue_check(ref_read(a), ref_read(a), rd);
                end
            end
            a = burst_next(a, bte);
        end
        cyc_w[p] = 1'b0; // next request may follow in this same cycle
        stb_w[p] = 1'b0;
    endtask

    always @(negedge clk) begin
        if (ack_r[0]) begin
            ack_cnt[0]++;
        end
        if (ack_r[1]) begin
            ack_cnt[1]++;
        end
    end

    initial begin : compare_reads
        logic [WIDE_DATA_W-1:0] exp_v, alt_v, act_v;
        forever begin
            @(posedge clk);
            while (act_q.size() > 0) begin
                exp_v = exp_q.pop_front();
                alt_v = alt_q.pop_front();
                act_v = act_q.pop_front();
                check_cnt++;
                if (act_v !== exp_v && act_v !== alt_v) begin
                    $display("Mismatch at %0t: read %h, expected %h", $time, act_v, exp_v);
                    error_cnt++;
                end
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        logic [WIDE_DATA_W-1:0] rd, rd2, old_v, new_v;
        logic [WIDE_ADDR_W-1:0] a;
        logic [WIDE_SEL_W-1:0]  sel;
        int                     errs, acks_f, acks_d;
        other_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_base     = 0;
        lfsr_q = 16'd17;
        cyc_w  = '{1'b0, 1'b0};
        stb_w  = '{1'b0, 1'b0};
        we_w   = '{1'b0, 1'b0};
        adr_w  = '{29'd0, 29'd0};
        dat_w  = '{64'd0, 64'd0};
        sel_w  = '{8'd0, 8'd0};
        cti_w  = '{CTI_CLASSIC, CTI_CLASSIC};
        bte_w  = '{BTE_LINEAR, BTE_LINEAR};
        rst    = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs = other_errs;
        repeat (10) begin
            @(negedge clk);
            if (ack_r[0] || ack_r[1]) begin
                $display("ack_o went high at %0t although no request was made", $time);
                other_errs++;
            end
        end
        report_test("reset", errs);

        errs = other_errs;
        repeat (8) begin
            a = WIDE_ADDR_W'(rand_bits(8));
            wide_burst(1'b0, 1'b1, a, 1, BTE_LINEAR, 8'hFF, 1'b1, rd);
            wide_burst(1'b0, 1'b0, a, 1, BTE_LINEAR, 8'hFF, 1'b1, rd);
        end
        report_test("single beats", errs);

        errs = other_errs;
        repeat (8) begin
            a   = WIDE_ADDR_W'(rand_bits(8));
            sel = WIDE_SEL_W'(rand_bits(8));
            wide_burst(1'b1, 1'b1, a, 1, BTE_LINEAR, 8'hFF, 1'b1, rd);
            wide_burst(1'b1, 1'b1, a, 1, BTE_LINEAR, sel, 1'b1, rd); // partial overwrite
            wide_burst(1'b1, 1'b0, a, 1, BTE_LINEAR, 8'hFF, 1'b1, rd);
        end
        report_test("byte enables", errs);

        errs = other_errs;
        for (int i = 0; i < 8; i++) begin
            wide_burst(1'b0, 1'b1, WIDE_ADDR_W'(9'h100 + i), 1, BTE_LINEAR, 8'hFF, 1'b1, rd);
        end
        @(negedge clk);
        acks_f = ack_cnt[0];
        wide_burst(1'b0, 1'b0, 29'h100, 4, BTE_LINEAR, 8'hFF, 1'b1, rd);
        wide_burst(1'b0, 1'b0, 29'h106, 4, BTE_WRAP4, 8'hFF, 1'b1, rd); // 6 7 4 5
        @(negedge clk);
        if (ack_cnt[0] - acks_f != 8) begin
            $display("Mismatch at %0t: %0d ack pulses in two bursts, expected 8",
                     $time, ack_cnt[0] - acks_f);
            other_errs++;
        end
        report_test("bursts", errs);

        errs = other_errs;
        @(negedge clk);
        acks_f = ack_cnt[0];
        acks_d = ack_cnt[1];
        fork
            wide_burst(1'b0, 1'b1, 29'h140, 8, BTE_LINEAR, 8'hFF, 1'b1, rd);
            wide_burst(1'b1, 1'b1, 29'h183, 8, BTE_WRAP8, 8'hFF, 1'b1, rd2);
        join
        fork
            wide_burst(1'b0, 1'b0, 29'h183, 8, BTE_WRAP8, 8'hFF, 1'b1, rd); // cross read
            wide_burst(1'b1, 1'b0, 29'h140, 8, BTE_LINEAR, 8'hFF, 1'b1, rd2);
        join
        @(negedge clk);
        if (ack_cnt[0] - acks_f != 16 || ack_cnt[1] - acks_d != 16) begin
            $display("Mismatch at %0t: ack pulses fetch %0d data %0d, expected 16 each",
                     $time, ack_cnt[0] - acks_f, ack_cnt[1] - acks_d);
            other_errs++;
        end
        report_test("contention", errs);

        errs = other_errs;
        for (int i = 0; i < 4; i++) begin
            a = WIDE_ADDR_W'(9'h1F0 + i);
            wide_burst(1'b1, 1'b1, a, 1, BTE_LINEAR, 8'hFF, 1'b1, rd);
            old_v = ref_read(a);
            @(negedge clk); // both bridges idle, so the arbiter sees a tie
            fork
                wide_burst(1'b1, 1'b1, a, 1, BTE_LINEAR, 8'hFF, 1'b0, rd2);
                wide_burst(1'b0, 1'b0, a, 1, BTE_LINEAR, 8'hFF, 1'b0, rd);
            join
            new_v = ref_read(a);
            queue_check(old_v, new_v, rd); // whole old or whole new word
            wide_burst(1'b0, 1'b0, a, 1, BTE_LINEAR, 8'hFF, 1'b1, rd);
        end
        report_test("interleaving", errs);

        $display("%0d tests, %0d failed, %0d reads checked, %0d errors",
                 tests_run, tests_failed, check_cnt, error_cnt + other_errs);
        if (tests_failed == 0 && error_cnt + other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // waits for pending compares, then prints the verdict of one test
    task automatic report_test(input string name, input int errs_before);
        int errs_now;
        while (act_q.size() > 0) begin
            @(negedge clk);
        end
        errs_now = other_errs + error_cnt;
        tests_run++;
        if (errs_now == errs_before + err_base) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errs_now - errs_before - err_base);
        end
        err_base = error_cnt;
    endtask

endmodule

`default_nettype wire

/* dual_port_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_port_mem_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  fetch_cyc_i,
    input  logic                                  fetch_stb_i,
    input  logic                                  fetch_we_i,
    input  logic [wb_bridge_pkg::WIDE_ADDR_W-1:0] fetch_adr_i,
    input  logic [wb_bridge_pkg::WIDE_DATA_W-1:0] fetch_dat_i,
    input  logic [wb_bridge_pkg::WIDE_SEL_W-1:0]  fetch_sel_i,
    input  wb_bridge_pkg::cti_e                   fetch_cti_i,
    input  wb_bridge_pkg::bte_e                   fetch_bte_i,
    output logic [wb_bridge_pkg::WIDE_DATA_W-1:0] fetch_dat_o,
    output logic                                  fetch_ack_o,
    input  logic                                  data_cyc_i,
    input  logic                                  data_stb_i,
    input  logic                                  data_we_i,
    input  logic [wb_bridge_pkg::WIDE_ADDR_W-1:0] data_adr_i,
    input  logic [wb_bridge_pkg::WIDE_DATA_W-1:0] data_dat_i,
    input  logic [wb_bridge_pkg::WIDE_SEL_W-1:0]  data_sel_i,
    input  wb_bridge_pkg::cti_e                   data_cti_i,
    input  wb_bridge_pkg::bte_e                   data_bte_i,
    output logic [wb_bridge_pkg::WIDE_DATA_W-1:0] data_dat_o,
    output logic                                  data_ack_o
);
    import wb_bridge_pkg::*;

    // fetch bridge to arbiter
    logic                     m0_cyc, m0_stb, m0_we, m0_ack;
    logic [31:0]              m0_adr;
    logic [NARROW_DATA_W-1:0] m0_dat_w, m0_dat_r;
    logic [NARROW_SEL_W-1:0]  m0_sel;

    // data bridge to arbiter
    logic                     m1_cyc, m1_stb, m1_we, m1_ack;
    logic [31:0]              m1_adr;
    logic [NARROW_DATA_W-1:0] m1_dat_w, m1_dat_r;
    logic [NARROW_SEL_W-1:0]  m1_sel;

    // arbiter to sram
    logic                     s_cyc, s_stb, s_we, s_ack;
    logic [31:0]              s_adr;
    logic [NARROW_DATA_W-1:0] s_dat_w, s_dat_r;
    logic [NARROW_SEL_W-1:0]  s_sel;

    wb64_to_wb32_bridge u_bridge_fetch (
        .clk     (clk),
        .rst     (rst),
        .cyc_i   (fetch_cyc_i),
        .stb_i   (fetch_stb_i),
        .we_i    (fetch_we_i),
        .adr_i   (fetch_adr_i),
        .dat_i   (fetch_dat_i),
        .sel_i   (fetch_sel_i),
        .cti_i   (fetch_cti_i),
        .bte_i   (fetch_bte_i),
        .dat_o   (fetch_dat_o),
        .ack_o   (fetch_ack_o),
        .n_cyc_o (m0_cyc),
        .n_stb_o (m0_stb),
        .n_we_o  (m0_we),
        .n_adr_o (m0_adr),
        .n_dat_o (m0_dat_w),
        .n_sel_o (m0_sel),
        .n_dat_i (m0_dat_r),
        .n_ack_i (m0_ack)
    );

    wb64_to_wb32_bridge u_bridge_data (
        .clk     (clk),
        .rst     (rst),
        .cyc_i   (data_cyc_i),
        .stb_i   (data_stb_i),
        .we_i    (data_we_i),
        .adr_i   (data_adr_i),
        .dat_i   (data_dat_i),
        .sel_i   (data_sel_i),
        .cti_i   (data_cti_i),
        .bte_i   (data_bte_i),
        .dat_o   (data_dat_o),
        .ack_o   (data_ack_o),
        .n_cyc_o (m1_cyc),
        .n_stb_o (m1_stb),
        .n_we_o  (m1_we),
        .n_adr_o (m1_adr),
        .n_dat_o (m1_dat_w),
        .n_sel_o (m1_sel),
        .n_dat_i (m1_dat_r),
        .n_ack_i (m1_ack)
    );

    wb32_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .m0_cyc_i (m0_cyc),
        .m0_stb_i (m0_stb),
        .m0_we_i  (m0_we),
        .m0_adr_i (m0_adr),
        .m0_dat_i (m0_dat_w),
        .m0_sel_i (m0_sel),
        .m0_dat_o (m0_dat_r),
        .m0_ack_o (m0_ack),
        .m1_cyc_i (m1_cyc),
        .m1_stb_i (m1_stb),
        .m1_we_i  (m1_we),
        .m1_adr_i (m1_adr),
        .m1_dat_i (m1_dat_w),
        .m1_sel_i (m1_sel),
        .m1_dat_o (m1_dat_r),
        .m1_ack_o (m1_ack),
        .s_cyc_o  (s_cyc),
        .s_stb_o  (s_stb),
        .s_we_o   (s_we),
        .s_adr_o  (s_adr),
        .s_dat_o  (s_dat_w),
        .s_sel_o  (s_sel),
        .s_dat_i  (s_dat_r),
        .s_ack_i  (s_ack)
    );

    wb32_sram u_sram (
        .clk   (clk),
        .rst   (rst),
        .cyc_i (s_cyc),
        .stb_i (s_stb),
        .we_i  (s_we),
        .adr_i (s_adr),
        .dat_i (s_dat_w),
        .sel_i (s_sel),
        .dat_o (s_dat_r),
        .ack_o (s_ack)
    );

endmodule

`default_nettype wire

/* wb32_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module wb32_sram (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    cyc_i,
    input  logic                                    stb_i,
    input  logic                                    we_i,
    input  logic [31:0]                             adr_i,
    input  logic [wb_bridge_pkg::NARROW_DATA_W-1:0] dat_i,
    input  logic [wb_bridge_pkg::NARROW_SEL_W-1:0]  sel_i,
    output logic [wb_bridge_pkg::NARROW_DATA_W-1:0] dat_o,
    output logic                                    ack_o
);
    import wb_bridge_pkg::*;

    logic [NARROW_DATA_W-1:0]  mem [2**MEM_WORDS_LOG2];
    logic [MEM_WORDS_LOG2-1:0] word_idx;
    logic                      access;

    assign word_idx = adr_i[MEM_WORDS_LOG2+1:2]; // upper bits alias
    assign access   = cyc_i && stb_i && !ack_o;  // new request, no ack pending

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access; // one cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            for (int b = 0; b < NARROW_SEL_W; b++) begin
                if (we_i && sel_i[b]) begin
                    mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
            dat_o <= mem[word_idx]; // read before write
        end
    end

endmodule

`default_nettype wire

/* wb32_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb32_arbiter (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    m0_cyc_i,
    input  logic                                    m0_stb_i,
    input  logic                                    m0_we_i,
    input  logic [31:0]                             m0_adr_i,
    input  logic [wb_bridge_pkg::NARROW_DATA_W-1:0] m0_dat_i,
    input  logic [wb_bridge_pkg::NARROW_SEL_W-1:0]  m0_sel_i,
    output logic [wb_bridge_pkg::NARROW_DATA_W-1:0] m0_dat_o,
    output logic                                    m0_ack_o,
    input  logic                                    m1_cyc_i,
    input  logic                                    m1_stb_i,
    input  logic                                    m1_we_i,
    input  logic [31:0]                             m1_adr_i,
    input  logic [wb_bridge_pkg::NARROW_DATA_W-1:0] m1_dat_i,
    input  logic [wb_bridge_pkg::NARROW_SEL_W-1:0]  m1_sel_i,
    output logic [wb_bridge_pkg::NARROW_DATA_W-1:0] m1_dat_o,
    output logic                                    m1_ack_o,
    output logic                                    s_cyc_o,
    output logic                                    s_stb_o,
    output logic                                    s_we_o,
    output logic [31:0]                             s_adr_o,
    output logic [wb_bridge_pkg::NARROW_DATA_W-1:0] s_dat_o,
    output logic [wb_bridge_pkg::NARROW_SEL_W-1:0]  s_sel_o,
    input  logic [wb_bridge_pkg::NARROW_DATA_W-1:0] s_dat_i,
    input  logic                                    s_ack_i
);

    logic gnt_vld_q;  // a master owns the slave
    logic gnt_q;      // 0 = m0, 1 = m1
    logic last_q;     // winner of the last arbitration
    logic hold;
    logic pick;

    // grant stays while the owner keeps its cycle open
    assign hold = gnt_vld_q && (gnt_q ? m1_cyc_i : m0_cyc_i);

    // round robin on a tie, else whoever asks
    assign pick = (m0_cyc_i && m1_cyc_i) ? ~last_q : m1_cyc_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gnt_vld_q <= 1'b0;
            gnt_q     <= 1'b0;
            last_q    <= 1'b1; // so m0 wins first
        end else if (!hold) begin
            gnt_vld_q <= m0_cyc_i || m1_cyc_i;
            if (m0_cyc_i || m1_cyc_i) begin
                gnt_q  <= pick;
                last_q <= pick;
            end
        end
    end

    // request path from the registered grant
    assign s_cyc_o = gnt_vld_q && (gnt_q ? m1_cyc_i : m0_cyc_i);
    assign s_stb_o = gnt_vld_q && (gnt_q ? m1_stb_i : m0_stb_i);
    assign s_we_o  = gnt_q ? m1_we_i  : m0_we_i;
    assign s_adr_o = gnt_q ? m1_adr_i : m0_adr_i;
    assign s_dat_o = gnt_q ? m1_dat_i : m0_dat_i;
    assign s_sel_o = gnt_q ? m1_sel_i : m0_sel_i;

    // ack only to the owner, read data to both
    assign m0_ack_o = s_ack_i && gnt_vld_q && !gnt_q;
    assign m1_ack_o = s_ack_i && gnt_vld_q && gnt_q;
    assign m0_dat_o = s_dat_i;
    assign m1_dat_o = s_dat_i;

endmodule

`default_nettype wire

/* wb64_to_wb32_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module wb64_to_wb32_bridge (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    cyc_i,
    input  logic                                    stb_i,
    input  logic                                    we_i,
    input  logic [wb_bridge_pkg::WIDE_ADDR_W-1:0]   adr_i,
    input  logic [wb_bridge_pkg::WIDE_DATA_W-1:0]   dat_i,
    input  logic [wb_bridge_pkg::WIDE_SEL_W-1:0]    sel_i,
    input  wb_bridge_pkg::cti_e                     cti_i,
    input  wb_bridge_pkg::bte_e                     bte_i,
    output logic [wb_bridge_pkg::WIDE_DATA_W-1:0]   dat_o,
    output logic                                    ack_o,
    output logic                                    n_cyc_o,
    output logic                                    n_stb_o,
    output logic                                    n_we_o,
    output logic [31:0]                             n_adr_o,
    output logic [wb_bridge_pkg::NARROW_DATA_W-1:0] n_dat_o,
    output logic [wb_bridge_pkg::NARROW_SEL_W-1:0]  n_sel_o,
    input  logic [wb_bridge_pkg::NARROW_DATA_W-1:0] n_dat_i,
    input  logic                                    n_ack_i
);
    import wb_bridge_pkg::*;

    bridge_state_e              state_q, state_d;
    logic                       we_q, we_d;
    cti_e                       cti_q, cti_d;
    bte_e                       bte_q, bte_d;
    logic [WIDE_ADDR_W-1:0]     adr_q, adr_d;
    logic [WIDE_SEL_W-1:0]      sel_q, sel_d;
    logic [WIDE_DATA_W-1:0]     dat_q, dat_d;
    logic [NARROW_DATA_W-1:0]   low_rd_q, low_rd_d; // low read word, held until high ack

    // next 64-bit word address of a burst, wrapping inside aligned groups
    function automatic logic [WIDE_ADDR_W-1:0] next_addr(
        input logic [WIDE_ADDR_W-1:0] a,
        input bte_e                   bte
    );
        logic [WIDE_ADDR_W-1:0] inc;
        inc = a + 1'b1;
        case (bte)
            BTE_WRAP4:  next_addr = {a[WIDE_ADDR_W-1:2], inc[1:0]};
            BTE_WRAP8:  next_addr = {a[WIDE_ADDR_W-1:3], inc[2:0]};
            BTE_WRAP16: next_addr = {a[WIDE_ADDR_W-1:4], inc[3:0]};
            default:    next_addr = inc; // linear
        endcase
    endfunction

    assign dat_o   = {n_dat_i, low_rd_q}; // high word straight from memory
    assign n_cyc_o = (state_q != ST_IDLE); // held across a whole burst
    assign n_we_o  = we_q;

    always_comb begin
        state_d  = state_q;
        we_d     = we_q;
        cti_d    = cti_q;
        bte_d    = bte_q;
        adr_d    = adr_q;
        sel_d    = sel_q;
        dat_d    = dat_q;
        low_rd_d = low_rd_q;
        ack_o    = 1'b0;
        n_stb_o  = 1'b0;
        n_adr_o  = {adr_q, 3'b000};
        n_sel_o  = sel_q[NARROW_SEL_W-1:0];
        n_dat_o  = dat_q[NARROW_DATA_W-1:0];

        case (state_q)
            ST_IDLE: begin
                if (cyc_i && stb_i) begin
                    state_d = ST_LOW;
                    we_d    = we_i;
                    cti_d   = cti_i;
                    bte_d   = bte_i;
                    adr_d   = adr_i;
                    sel_d   = sel_i;
                    dat_d   = dat_i;
                end
            end
            ST_LOW: begin
                n_stb_o = 1'b1;
                if (n_ack_i) begin
                    low_rd_d = n_dat_i;
                    state_d  = ST_HIGH;
                end
            end
            ST_HIGH: begin
                n_stb_o = 1'b1;
                n_adr_o = {adr_q, 3'b100};
                n_sel_o = sel_q[WIDE_SEL_W-1:NARROW_SEL_W];
                n_dat_o = dat_q[WIDE_DATA_W-1:NARROW_DATA_W];
                if (n_ack_i) begin
                    ack_o = 1'b1; // wide beat done with the high word
                    if (cti_q == CTI_INCR) begin
                        adr_d   = next_addr(adr_q, bte_q);
                        state_d = ST_WAIT_BEAT;
                    end else begin
                        state_d = ST_IDLE;
                    end
                end
            end
            ST_WAIT_BEAT: begin
                if (!cyc_i) begin
                    state_d = ST_IDLE; // master gave up the burst
                end else if (stb_i) begin
                    state_d = ST_LOW;
                    cti_d   = cti_i;
                    bte_d   = bte_i;
                    sel_d   = sel_i;
                    dat_d   = dat_i;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
            we_q    <= 1'b0;
            cti_q   <= CTI_CLASSIC;
            bte_q   <= BTE_LINEAR;
        end else begin
            state_q <= state_d;
            we_q    <= we_d;
            cti_q   <= cti_d;
            bte_q   <= bte_d;
        end
    end

    always_ff @(posedge clk) begin
        adr_q    <= adr_d;
        sel_q    <= sel_d;
        dat_q    <= dat_d;
        low_rd_q <= low_rd_d;
    end

endmodule

`default_nettype wire

/* wb_bridge_pkg.sv */
`default_nettype none

package wb_bridge_pkg;

    // master side, 64-bit Wishbone
    localparam int WIDE_ADDR_W = 29; // address counted in 64-bit words
    localparam int WIDE_DATA_W = 64;
    localparam int WIDE_SEL_W  = 8;

    // memory side, 32-bit Wishbone with byte addresses
    localparam int NARROW_DATA_W = 32;
    localparam int NARROW_SEL_W  = 4;

    // sram depth in 32-bit words, as a power of two
    localparam int MEM_WORDS_LOG2 = 10;

    // Wishbone cycle type tag
    typedef enum logic [2:0] {
        CTI_CLASSIC = 3'b000,
        CTI_INCR    = 3'b010, // incrementing burst
        CTI_END     = 3'b111  // last beat of a burst
    } cti_e;

    // Wishbone burst type tag
    typedef enum logic [1:0] {
        BTE_LINEAR = 2'b00,
        BTE_WRAP4  = 2'b01,
        BTE_WRAP8  = 2'b10,
        BTE_WRAP16 = 2'b11
    } bte_e;

    // 64-to-32 bridge FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOW,       // low word access
        ST_HIGH,      // high word access
        ST_WAIT_BEAT  // burst, waiting for next strobe
    } bridge_state_e;

endpackage

`default_nettype wire
